// File: compile.f
rtl/mem_map_pkg.sv
rtl/ctrl_map_pkg.sv
rtl/rom_loader.sv
rtl/rom_fetch.sv
rtl/toggle_ram.sv
rtl/input_mapper.sv
rtl/arcade_board.sv
testbench/arcade_board_chk.sv
testbench/arcade_board_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the arcade_board testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module arcade_board_tb -o arcade_board_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/arcade_board_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

// File: testbench/arcade_board_tb.sv
/*
 * Full image download, then random CPU and sound reads, a partial reload and key events.
 * Runs about 200k clocks, bounded by a cycle limit.
 */
`default_nettype none

module arcade_board_tb;
	import ctrl_map_pkg::*;

	localparam int N_IMG    = 'hC000; // CPU and sound regions
	localparam int N_RW     = 64;     // Bytes rewritten by the second download
	localparam int N_CPU_RD = 200;
	localparam int N_SND_RD = 200;
	localparam int N_KEY    = 200;
	localparam int N_READS  = N_CPU_RD + N_SND_RD + 2 * N_RW + 1; // Stray strobe read too
	localparam int LIMIT    = (N_IMG + N_RW + 1) * 4 + N_READS * 5 + N_KEY * 3 + 200;

	logic        clk_sys = 1'b0;
	logic        arst_n;
	logic        ioctl_download, ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        reset_req, reset_button;
	logic        key_strobe, key_pressed;
	logic [7:0]  key_code, joystick_0, joystick_1;
	logic        cpu_rom_rd, snd_rom_rd;
	logic [14:0] cpu_rom_addr;
	logic [13:0] snd_rom_addr;
	logic [7:0]  cpu_rom_byte, snd_rom_byte;
	logic        core_reset, rom_loaded;
	logic        up1, down1, fire1, bomb1, up2, down2, fire2, bomb2;
	logic        coin, start1, start2, start3;

	logic [7:0]  img [N_IMG]; // Reference image
	logic [7:0]  exp_btn;     // Reference buttons in btn_e order
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;

	always #2 clk_sys = ~clk_sys;

	arcade_board u_arcade_board (.*);

	bind arcade_board arcade_board_chk u_arcade_board_chk (
		.clk_sys, .arst_n, .ioctl_download, .wr_pulse, .cpu_req, .cpu_rom_rd,
		.snd_req, .snd_rom_rd, .core_reset, .rom_loaded
	);

	// Run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: run exceeded %0d cycles", LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got %h exp %h", name, got, exp);
		end
	endtask

	// ==================================================
	// Download and read helpers
	// ==================================================
	task automatic send_byte(input int a, input logic [7:0] d);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= 25'(a);
		ioctl_dout <= d;
		img[a] = d;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		repeat (2) @(posedge clk_sys); // Four clocks per byte
	endtask

	task automatic read_and_check(input int a);
		@(posedge clk_sys);
		if (a < 'h8000) begin
			cpu_rom_rd   <= 1'b1;
			snd_rom_rd   <= 1'b0;
			cpu_rom_addr <= 15'(a);
		end else begin
			cpu_rom_rd   <= 1'b0;
			snd_rom_rd   <= 1'b1;
			snd_rom_addr <= 14'(a - 'h8000);
		end
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		if (a < 'h8000) compare_value("cpu_rom_byte", 32'(cpu_rom_byte), 32'(img[a]));
		else compare_value("snd_rom_byte", 32'(snd_rom_byte), 32'(img[a]));
	endtask

	// Mapped code for a random pick
	function automatic logic [7:0] mapped_code(input int n);
		case (n)
			0: return KEY_UP;
			1: return KEY_DOWN;
			2: return KEY_ESC;
			3: return KEY_F1;
			4: return KEY_F2;
			5: return KEY_F3;
			6: return KEY_SPACE;
			default: return KEY_ALT;
		endcase
	endfunction

	function automatic int btn_index_of(input logic [7:0] code);
		case (code)
			8'h75:   return 0; // Up
			8'h72:   return 1; // Down
			8'h76:   return 2; // Coin
			8'h05:   return 3;
			8'h06:   return 4;
			8'h04:   return 5;
			8'h29:   return 6; // Fire
			8'h11:   return 7; // Bomb
			default: return -1;
		endcase
	endfunction

	task automatic key_event(input logic [7:0] code, input logic pressed);
		logic [7:0] j0;
		logic [7:0] j1;
		int         idx;
		j0 = 8'($urandom);
		j1 = 8'($urandom);
		@(posedge clk_sys);
		key_strobe  <= 1'b1;
		key_code    <= code;
		key_pressed <= pressed;
		joystick_0  <= j0;
		joystick_1  <= j1;
		idx = btn_index_of(code);
		if (idx >= 0) exp_btn[idx] = pressed;
		@(posedge clk_sys);
		key_strobe <= 1'b0;
		@(negedge clk_sys);
		compare_value("up1", 32'(up1), 32'(exp_btn[0] | j0[3]));
		compare_value("down1", 32'(down1), 32'(exp_btn[1] | j0[2]));
		compare_value("fire1", 32'(fire1), 32'(exp_btn[6] | j0[4]));
		compare_value("bomb1", 32'(bomb1), 32'(exp_btn[7] | j0[5]));
		compare_value("coin", 32'(coin), 32'(exp_btn[2]));
		compare_value("start1", 32'(start1), 32'(exp_btn[3]));
		compare_value("start2", 32'(start2), 32'(exp_btn[4]));
		compare_value("start3", 32'(start3), 32'(exp_btn[5]));
		compare_value("player2", 32'({up2, down2, fire2, bomb2}),
			32'({j1[3], j1[2], j1[4], j1[5]}));
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		int rw_addr [N_RW];
		int n;
		int stray;
		void'($urandom(32'hd059cd74));
		arst_n         = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		reset_req      = 1'b0;
		reset_button   = 1'b0;
		key_strobe     = 1'b0;
		key_pressed    = 1'b0;
		key_code       = '0;
		joystick_0     = '0;
		joystick_1     = '0;
		cpu_rom_rd     = 1'b0;
		snd_rom_rd     = 1'b0;
		cpu_rom_addr   = '0;
		snd_rom_addr   = '0;
		exp_btn        = '0;
		repeat (4) @(posedge clk_sys);
		arst_n <= 1'b1;

		// Full image download
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		for (int a = 0; a < N_IMG; a++) send_byte(a, 8'($urandom));
		@(negedge clk_sys);
		compare_value("core_reset", 32'(core_reset), 32'h1);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (core_reset && n < 3) begin
			@(negedge clk_sys);
			n++;
		end
		if (core_reset) begin
			errors++;
			$display("core_reset did not fall after the download ended");
		end
		compare_value("rom_loaded", 32'(rom_loaded), 32'h1);

		// Reset request
		@(posedge clk_sys);
		reset_req <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		compare_value("core_reset", 32'(core_reset), 32'h1);
		@(posedge clk_sys);
		reset_req <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		compare_value("core_reset", 32'(core_reset), 32'h0);

		// Strobe outside a download leaves the image alone
		stray = int'($urandom % N_IMG);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= 25'(stray);
		ioctl_dout <= ~img[stray];
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		repeat (2) @(posedge clk_sys);
		read_and_check(stray);

		for (int i = 0; i < N_CPU_RD; i++) read_and_check(int'($urandom % 'h8000));
		for (int i = 0; i < N_SND_RD; i++) read_and_check('h8000 + int'($urandom % 'h4000));

		// Partial reload
		@(posedge clk_sys);
		cpu_rom_rd     <= 1'b0;
		snd_rom_rd     <= 1'b0;
		ioctl_download <= 1'b1;
		for (int i = 0; i < N_RW; i++) begin
			rw_addr[i] = int'($urandom % N_IMG);
			send_byte(rw_addr[i], 8'($urandom));
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (4) @(posedge clk_sys);
		for (int i = 0; i < N_RW; i++) begin
			read_and_check(rw_addr[i]);
			read_and_check(rw_addr[i] ^ 1); // Other byte of the same word
		end
		@(posedge clk_sys);
		cpu_rom_rd <= 1'b0;
		snd_rom_rd <= 1'b0;

		// Key events with about a third unmapped
		for (int i = 0; i < N_KEY; i++) begin
			if ($urandom % 3 == 0) key_event(8'($urandom), 1'($urandom));
			else key_event(mapped_code(int'($urandom % 8)), 1'($urandom));
		end

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/arcade_board_chk.sv
/*
 * Bound to arcade_board. Covers both ROM ports, the write path and the core reset.
 */
`default_nettype none

module arcade_board_chk (
	input logic clk_sys,
	input logic arst_n,
	input logic ioctl_download,
	input logic wr_pulse,
	input logic cpu_req,
	input logic cpu_rom_rd,
	input logic snd_req,
	input logic snd_rom_rd,
	input logic core_reset,
	input logic rom_loaded
);

	// Request toggles come from a write pulse or a read strobe
	cpu_req_cause: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(cpu_req != $past(cpu_req)) |-> $past(wr_pulse || cpu_rom_rd))
		else $error("cpu_req toggled without a write pulse or a read");

	snd_req_cause: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(snd_req != $past(snd_req)) |-> $past(wr_pulse || snd_rom_rd))
		else $error("snd_req toggled without a write pulse or a read");

	wr_in_download: assert property (@(posedge clk_sys) disable iff (!arst_n)
		wr_pulse |-> ioctl_download)
		else $error("write pulse outside a download");

	reset_until_loaded: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!rom_loaded |-> core_reset)
		else $error("core_reset low before the image was loaded");

endmodule

`default_nettype wire

// File: rtl/arcade_board.sv
/*
 * Board glue around the game core. Read data is valid three clocks after a new
 * address with rd and stays valid while the address is held.
 */
`default_nettype none

module arcade_board (
	input  logic                                clk_sys,
	input  logic                                arst_n,
	input  logic                                ioctl_download,
	input  logic                                ioctl_wr,
	input  logic [mem_map_pkg::IOCTL_AW-1:0]    ioctl_addr,
	input  logic [7:0]                          ioctl_dout,
	input  logic                                reset_req,
	input  logic                                reset_button,
	input  logic                                key_strobe,
	input  logic                                key_pressed,
	input  logic [7:0]                          key_code,
	input  logic [7:0]                          joystick_0,
	input  logic [7:0]                          joystick_1,
	input  logic                                cpu_rom_rd,
	input  logic [mem_map_pkg::CPU_ROM_AW-1:0]  cpu_rom_addr,
	input  logic                                snd_rom_rd,
	input  logic [mem_map_pkg::SND_ROM_AW-1:0]  snd_rom_addr,
	output logic [7:0]                          cpu_rom_byte,
	output logic [7:0]                          snd_rom_byte,
	output logic                                core_reset,
	output logic                                rom_loaded,
	output logic                                up1,
	output logic                                down1,
	output logic                                fire1,
	output logic                                bomb1,
	output logic                                up2,
	output logic                                down2,
	output logic                                fire2,
	output logic                                bomb2,
	output logic                                coin,
	output logic                                start1,
	output logic                                start2,
	output logic                                start3
);
	import mem_map_pkg::*;

	logic                wr_pulse;
	logic [IOCTL_AW-1:0] wr_addr;
	logic [7:0]          wr_data;

	// Port 1, main CPU
	logic                cpu_req, cpu_ack, cpu_we;
	logic [IOCTL_AW-2:0] cpu_word_addr;
	logic [1:0]          cpu_ds;
	logic [15:0]         cpu_wdata, cpu_q;

	// Port 2, sound board
	logic                snd_req, snd_ack, snd_we;
	logic [IOCTL_AW-2:0] snd_word_addr;
	logic [1:0]          snd_ds;
	logic [15:0]         snd_wdata, snd_q;

	rom_loader u_rom_loader (
		.clk_sys, .arst_n, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.reset_req, .reset_button, .wr_pulse, .wr_addr, .wr_data, .rom_loaded, .core_reset
	);

	// ==================================================
	// ROM ports
	// ==================================================
	rom_fetch #(.ADDR_W(CPU_ROM_AW), .BASE_WORD(CPU_BASE_WORD)) u_cpu_fetch (
		.clk_sys, .arst_n, .download(ioctl_download), .wr_pulse, .wr_addr, .wr_data,
		.rd(cpu_rom_rd), .addr(cpu_rom_addr), .byte_out(cpu_rom_byte),
		.req(cpu_req), .ack(cpu_ack), .word_addr(cpu_word_addr), .ds(cpu_ds),
		.we(cpu_we), .wdata(cpu_wdata), .q(cpu_q)
	);

	toggle_ram #(.WORD_AW(CPU_WORD_AW)) u_cpu_ram (
		.clk_sys, .arst_n, .req(cpu_req), .word_addr(cpu_word_addr), .ds(cpu_ds),
		.we(cpu_we), .wdata(cpu_wdata), .ack(cpu_ack), .q(cpu_q)
	);

	rom_fetch #(.ADDR_W(SND_ROM_AW), .BASE_WORD(SND_BASE_WORD)) u_snd_fetch (
		.clk_sys, .arst_n, .download(ioctl_download), .wr_pulse, .wr_addr, .wr_data,
		.rd(snd_rom_rd), .addr(snd_rom_addr), .byte_out(snd_rom_byte),
		.req(snd_req), .ack(snd_ack), .word_addr(snd_word_addr), .ds(snd_ds),
		.we(snd_we), .wdata(snd_wdata), .q(snd_q)
	);

	toggle_ram #(.WORD_AW(SND_WORD_AW)) u_snd_ram (
		.clk_sys, .arst_n, .req(snd_req), .word_addr(snd_word_addr), .ds(snd_ds),
		.we(snd_we), .wdata(snd_wdata), .ack(snd_ack), .q(snd_q)
	);

	input_mapper u_input_mapper (
		.clk_sys, .arst_n, .key_strobe, .key_pressed, .key_code, .joystick_0, .joystick_1,
		.up1, .down1, .fire1, .bomb1, .up2, .down2, .fire2, .bomb2,
		.coin, .start1, .start2, .start3
	);

endmodule

`default_nettype wire

// File: rtl/input_mapper.sv
/*
 * Keyboard and joystick merge. Player 2 has no keyboard keys, joystick only.
 */
`default_nettype none

module input_mapper (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  logic [7:0] key_code,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	output logic       up1,
	output logic       down1,
	output logic       fire1,
	output logic       bomb1,
	output logic       up2,
	output logic       down2,
	output logic       fire2,
	output logic       bomb2,
	output logic       coin,
	output logic       start1,
	output logic       start2,
	output logic       start3
);
	import ctrl_map_pkg::*;

	logic [NUM_BTN-1:0] btn;

	// Make sets, break clears
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			btn <= '0;
		end else if (key_strobe) begin
			case (key_code)
				KEY_UP:    btn[BTN_UP]     <= key_pressed;
				KEY_DOWN:  btn[BTN_DOWN]   <= key_pressed;
				KEY_ESC:   btn[BTN_COIN]   <= key_pressed;
				KEY_F1:    btn[BTN_START1] <= key_pressed;
				KEY_F2:    btn[BTN_START2] <= key_pressed;
				KEY_F3:    btn[BTN_START3] <= key_pressed; // Dogfight
				KEY_SPACE: btn[BTN_FIRE]   <= key_pressed;
				KEY_ALT:   btn[BTN_BOMB]   <= key_pressed;
				default:   ;
			endcase
		end
	end

	// Joystick bits: 3 up, 2 down, 4 fire, 5 bomb
	assign up1    = btn[BTN_UP]   | joystick_0[3];
	assign down1  = btn[BTN_DOWN] | joystick_0[2];
	assign fire1  = btn[BTN_FIRE] | joystick_0[4];
	assign bomb1  = btn[BTN_BOMB] | joystick_0[5];

	assign up2    = joystick_1[3];
	assign down2  = joystick_1[2];
	assign fire2  = joystick_1[4];
	assign bomb2  = joystick_1[5];

	assign coin   = btn[BTN_COIN];
	assign start1 = btn[BTN_START1];
	assign start2 = btn[BTN_START2];
	assign start3 = btn[BTN_START3];

endmodule

`default_nettype wire

// File: rtl/toggle_ram.sv
/*
 * On-chip stand-in for one SDRAM port. One access per pending toggle, one clock each.
 * Writes beyond 2**WORD_AW words are dropped, reads wrap on the low address bits.
 */
`default_nettype none

module toggle_ram #(
	parameter int WORD_AW = 14
) (
	input  logic                              clk_sys,
	input  logic                              arst_n,
	input  logic                              req,
	input  logic [mem_map_pkg::IOCTL_AW-2:0]  word_addr,
	input  logic [1:0]                        ds,
	input  logic                              we,
	input  logic [15:0]                       wdata,
	output logic                              ack,
	output logic [15:0]                       q
);
	import mem_map_pkg::*;

	localparam int DEPTH = 2 ** WORD_AW;

	logic [15:0]        mem [DEPTH];
	logic [WORD_AW-1:0] idx;
	logic               pending;
	logic               in_range;

	assign pending  = req ^ ack;
	assign idx      = word_addr[WORD_AW-1:0];
	assign in_range = (word_addr[IOCTL_AW-2:WORD_AW] == '0);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) ack <= 1'b1; // Matches req after reset
		else if (pending) ack <= req;
	end

	always_ff @(posedge clk_sys) begin
		if (pending) begin
			if (we) begin
				if (in_range && ds[0]) mem[idx][7:0]  <= wdata[7:0];
				if (in_range && ds[1]) mem[idx][15:8] <= wdata[15:8];
			end else begin
				q <= mem[idx];
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/rom_fetch.sv
/*
 * One memory port requester. Reads are held off while an access is pending,
 * writes are not, so download bytes must be spaced wider than the store latency.
 */
`default_nettype none

module rom_fetch #(
	parameter int          ADDR_W    = 15,
	parameter logic [15:0] BASE_WORD = 16'h0000
) (
	input  logic                              clk_sys,
	input  logic                              arst_n,
	input  logic                              download,
	input  logic                              wr_pulse,
	input  logic [mem_map_pkg::IOCTL_AW-1:0]  wr_addr,
	input  logic [7:0]                        wr_data,
	input  logic                              rd,
	input  logic [ADDR_W-1:0]                 addr,
	output logic [7:0]                        byte_out,
	output logic                              req,
	input  logic                              ack,
	output logic [mem_map_pkg::IOCTL_AW-2:0]  word_addr,
	output logic [1:0]                        ds,
	output logic                              we,
	output logic [15:0]                       wdata,
	input  logic [15:0]                       q
);
	import mem_map_pkg::*;

	localparam logic [IOCTL_AW-2:0] BASE = (IOCTL_AW-1)'(BASE_WORD);

	logic [ADDR_W-1:0]   last_word; // Extra top bit, all ones never matches
	logic [IOCTL_AW-2:0] dl_word;
	logic [IOCTL_AW-2:0] rd_word;
	logic                busy;
	logic                rd_new;

	assign dl_word = wr_addr[IOCTL_AW-1:1] - BASE; // Wraps out of range below base
	assign rd_word = (IOCTL_AW-1)'(addr[ADDR_W-1:1]);
	assign busy    = req ^ ack;
	assign rd_new  = rd && !busy && ({1'b0, addr[ADDR_W-1:1]} != last_word);

	// ==================================================
	// Request toggle
	// ==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			req       <= 1'b1;
			we        <= 1'b0;
			last_word <= '1;
		end else if (download || wr_pulse) begin
			last_word <= '1; // Force a fetch after the download
			if (wr_pulse) begin
				req <= ~req;
				we  <= 1'b1;
			end
		end else if (rd_new) begin
			req       <= ~req;
			we        <= 1'b0;
			last_word <= {1'b0, addr[ADDR_W-1:1]};
		end
	end

	// Access payload, loaded with each toggle
	always_ff @(posedge clk_sys) begin
		if (wr_pulse) begin
			word_addr <= dl_word;
			ds        <= wr_addr[0] ? 2'b10 : 2'b01; // Odd bytes in the high lane
			wdata     <= {wr_data, wr_data};
		end else if (!download && rd_new) begin
			word_addr <= rd_word;
			ds        <= 2'b11;
		end
	end

	assign byte_out = addr[0] ? q[15:8] : q[7:0];

endmodule

`default_nettype wire

// File: rtl/rom_loader.sv
/*
 * Download front end. Expects ioctl_wr rises at least four clocks apart.
 * Once loaded the image stays flagged until arst_n, a reload does not reset the core.
 */
`default_nettype none

module rom_loader (
	input  logic                              clk_sys,
	input  logic                              arst_n,
	input  logic                              ioctl_download,
	input  logic                              ioctl_wr,
	input  logic [mem_map_pkg::IOCTL_AW-1:0]  ioctl_addr,
	input  logic [7:0]                        ioctl_dout,
	input  logic                              reset_req,
	input  logic                              reset_button,
	output logic                              wr_pulse,
	output logic [mem_map_pkg::IOCTL_AW-1:0]  wr_addr,
	output logic [7:0]                        wr_data,
	output logic                              rom_loaded,
	output logic                              core_reset
);

	logic       wr_last;
	logic [1:0] dl_sr; // Download level, two stages
	logic       wr_rise;

	assign wr_rise = ioctl_wr & ~wr_last;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_last    <= 1'b0;
			dl_sr      <= 2'b00;
			wr_pulse   <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			wr_last  <= ioctl_wr;
			dl_sr    <= {dl_sr[0], ioctl_download};
			wr_pulse <= wr_rise & ioctl_download;
			if (dl_sr[1] & ~dl_sr[0]) rom_loaded <= 1'b1; // End of download
			core_reset <= reset_req | reset_button | ~rom_loaded;
		end
	end

	// Byte and address held until the next strobe
	always_ff @(posedge clk_sys) begin
		if (wr_rise) begin
			wr_addr <= ioctl_addr;
			wr_data <= ioctl_dout;
		end
	end

endmodule

`default_nettype wire

// File: rtl/ctrl_map_pkg.sv
/*
 * Control panel map. PS/2 set 2 make codes only, extended prefixes are not decoded.
 */
`default_nettype none

package ctrl_map_pkg;

	// Scan codes the panel reacts to
	typedef enum logic [7:0] {
		KEY_F3    = 8'h04,
		KEY_F1    = 8'h05,
		KEY_F2    = 8'h06,
		KEY_ALT   = 8'h11,
		KEY_SPACE = 8'h29,
		KEY_DOWN  = 8'h72,
		KEY_UP    = 8'h75,
		KEY_ESC   = 8'h76
	} key_code_e;

	// Bit positions in the latched button vector
	typedef enum logic [2:0] {
		BTN_UP,
		BTN_DOWN,
		BTN_COIN,
		BTN_START1,
		BTN_START2,
		BTN_START3,
		BTN_FIRE,
		BTN_BOMB
	} btn_e;

	localparam int NUM_BTN = 8;

endpackage

`default_nettype wire

// File: rtl/mem_map_pkg.sv
/*
 * ROM image layout. CPU code at the bottom of the image, sound code from byte 0x8000.
 * Word addresses are byte addresses shifted right by one.
 */
`default_nettype none

package mem_map_pkg;

	// ==================================================
	// Address widths
	// ==================================================
	localparam int IOCTL_AW   = 25; // Download byte address
	localparam int CPU_ROM_AW = 15; // Main CPU byte address
	localparam int SND_ROM_AW = 14; // Sound CPU byte address

	localparam int CPU_WORD_AW = CPU_ROM_AW - 1;
	localparam int SND_WORD_AW = SND_ROM_AW - 1;

	// ==================================================
	// Region offsets, in words
	// ==================================================
	localparam logic [15:0] CPU_BASE_WORD = 16'h0000;
	localparam logic [15:0] SND_BASE_WORD = 16'h4000; // Byte 0x8000

endpackage

`default_nettype wire
